// ==== rtl/region_read_pkg.sv ====
`default_nettype none

package region_read_pkg;

    // data path widths.
    localparam int DATA_W        = 32;
    localparam int PROPS_W       = 128;
    localparam int DESC_PER_LINE = 4;
    localparam int ITER_W        = 16;

    // store geometry, region addresses wrap at 256.
    localparam int STORE_AW = 8;
    localparam int FIFO_AW  = 4;

    // output queue sizing.
    localparam int OUTQ_DEPTH  = 16;
    localparam int OUTQ_MARGIN = 3;

    // command word layout, shared with the descriptor words.
    localparam int CMD_OFFSET_LSB = 0;
    localparam int CMD_OFFSET_MSB = 13;
    localparam int CMD_USE_PROPS  = 14;
    localparam int CMD_KEEP_COUNT = 15;
    localparam int CMD_LENGTH_LSB = 16;
    localparam int CMD_LENGTH_MSB = 29;
    localparam int CMD_SOURCE_LSB = 30;
    localparam int CMD_SOURCE_MSB = 31;
    localparam int FIELD_W        = CMD_OFFSET_MSB - CMD_OFFSET_LSB + 1;

    typedef enum logic [1:0]
    {
        SRC_NONE = 2'd0,
        SRC_BRAM = 2'd1,
        SRC_FIFO = 2'd2,
        SRC_BOTH = 2'd3
    } read_source_e;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_BRAM_READ,
        ST_FIFO_READ,
        ST_FETCH_PROPS,
        ST_RECEIVE_PROPS,
        ST_READ_WITH_PROPS
    } reader_state_e;

endpackage

`default_nettype wire

// ==== rtl/read_config_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_config_regs
    import region_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  logic [DATA_W-1:0]    cmd_word,
    input  logic [ITER_W-1:0]    cmd_iterations,
    input  logic                 busy,
    input  logic                 op_done,
    output logic                 cmd_ready,
    output logic                 op_start,
    output read_source_e         cfg_source,
    output logic [FIELD_W-1:0]   cfg_offset,
    output logic [FIELD_W-1:0]   cfg_length,
    output logic                 cfg_use_props,
    output logic                 cfg_keep_count,
    output logic [ITER_W-1:0]    cfg_iterations,
    output logic [7:0]           ops_done
);
    logic start_pending;
    logic accept;

    // one command at a time, only while the reader sits idle.
    assign cmd_ready = !busy && !start_pending;
    assign accept    = cmd_valid && cmd_ready;
    assign op_start  = start_pending;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_pending <= 1'b0;
            ops_done      <= 8'd0;
        end
        else
        begin
            start_pending <= accept;
            if (op_done)
            begin
                ops_done <= ops_done + 8'd1;
            end
        end
    end

    // decoded fields stay stable for the whole operation.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cfg_source     <= read_source_e'(cmd_word[CMD_SOURCE_MSB:CMD_SOURCE_LSB]);
            cfg_offset     <= cmd_word[CMD_OFFSET_MSB:CMD_OFFSET_LSB];
            cfg_length     <= cmd_word[CMD_LENGTH_MSB:CMD_LENGTH_LSB];
            cfg_use_props  <= cmd_word[CMD_USE_PROPS];
            cfg_keep_count <= cmd_word[CMD_KEEP_COUNT];
            cfg_iterations <= cmd_iterations;
        end
    end

    // a start must never overlap a running operation.
    a_start_not_busy : assert property (@(posedge clk) disable iff (reset)
        op_start |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/local_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module local_store
    import region_read_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  logic                 wr_fifo,
    input  logic [STORE_AW-1:0]  wr_addr,
    input  logic [WIDTH-1:0]     wr_data,
    input  logic                 re,
    input  logic                 rd_fifo,
    input  logic [STORE_AW-1:0]  raddr,
    output logic                 rvalid,
    output logic [WIDTH-1:0]     rdata,
    output logic                 empty
);
    localparam int FIFO_DEPTH = 2 ** FIFO_AW;

    logic [WIDTH-1:0]   mem [0:2**STORE_AW-1];
    logic [WIDTH-1:0]   fifo_mem [0:FIFO_DEPTH-1];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    assign empty = (count == '0);
    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));

    // a push into a full FIFO is lost.
    assign push = wr_en && wr_fifo && !full;
    assign pop  = re && rd_fifo && !empty;

    always_ff @(posedge clk)
    begin
        if (wr_en && !wr_fifo)
        begin
            mem[wr_addr] <= wr_data;
        end
        if (push)
        begin
            fifo_mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= re;
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    // read data follows re by exactly one cycle.
    always_ff @(posedge clk)
    begin
        rdata <= rd_fifo ? fifo_mem[rd_ptr] : mem[raddr];
    end

    a_no_empty_pop : assert property (@(posedge clk) disable iff (reset)
        (re && rd_fifo) |-> !empty);

    a_no_full_push : assert property (@(posedge clk) disable iff (reset)
        (wr_en && wr_fifo) |-> !full);

endmodule

`default_nettype wire

// ==== rtl/region_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_reader
    import region_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 op_start,
    input  read_source_e         cfg_source,
    input  logic [FIELD_W-1:0]   cfg_offset,
    input  logic [FIELD_W-1:0]   cfg_length,
    input  logic                 cfg_use_props,
    input  logic                 cfg_keep_count,
    input  logic [ITER_W-1:0]    cfg_iterations,
    input  logic                 props_rvalid,
    input  logic [PROPS_W-1:0]   props_rdata,
    input  logic                 region_rvalid,
    input  logic [DATA_W-1:0]    region_rdata,
    input  logic                 region_empty,
    input  logic                 almost_full,
    output logic                 busy,
    output logic                 op_done,
    output logic                 props_re,
    output logic [STORE_AW-1:0]  props_raddr,
    output logic                 region_re,
    output logic                 region_rd_fifo,
    output logic [STORE_AW-1:0]  region_raddr,
    output logic                 push,
    output logic [DATA_W-1:0]    push_data
);
    localparam int POS_W = $clog2(DESC_PER_LINE);

    reader_state_e      state;
    logic [FIELD_W-1:0] line_count;
    logic [ITER_W-1:0]  iter_count;
    logic [ITER_W-1:0]  iter_last_idx;
    logic [FIELD_W-1:0] run_offset;
    logic [FIELD_W-1:0] desc_offset;
    logic [FIELD_W-1:0] desc_length;
    logic [DATA_W-1:0]  desc_word;
    logic [FIELD_W-1:0] cur_base;
    logic [FIELD_W-1:0] cur_length;
    logic               last_word;
    logic               last_iter;
    logic               empty_desc;
    logic               iter_end;

    assign busy = (state != ST_IDLE);

    // zero iterations run once.
    assign iter_last_idx = (cfg_iterations == '0) ? '0 : cfg_iterations - 1'b1;
    assign last_iter     = (iter_count == iter_last_idx);

    // descriptor picked by the low offset bits.
    assign desc_word  = props_rdata[DATA_W*run_offset[POS_W-1:0] +: DATA_W];
    assign empty_desc = (desc_word[CMD_LENGTH_MSB:CMD_LENGTH_LSB] == '0);

    assign props_re    = (state == ST_FETCH_PROPS);
    assign props_raddr = STORE_AW'(run_offset >> POS_W);

    assign cur_base   = (state == ST_READ_WITH_PROPS) ? desc_offset : run_offset;
    assign cur_length = (state == ST_READ_WITH_PROPS) ? desc_length : cfg_length;

    // reads stop while the output queue is nearly full.
    always_comb
    begin
        region_re = 1'b0;
        if (!almost_full)
        begin
            case (state)
                ST_BRAM_READ:       region_re = 1'b1;
                ST_FIFO_READ:       region_re = !region_empty;
                ST_READ_WITH_PROPS: region_re = 1'b1;
                default:            region_re = 1'b0;
            endcase
        end
    end

    assign region_rd_fifo = (state == ST_FIFO_READ);
    assign region_raddr   = STORE_AW'(cur_base + line_count);

    assign last_word = (line_count == cur_length - 1'b1);
    assign iter_end  = (region_re && last_word) ||
                       (state == ST_RECEIVE_PROPS && props_rvalid && empty_desc);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            op_done    <= 1'b0;
            push       <= 1'b0;
            line_count <= '0;
            iter_count <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            push    <= region_rvalid;
            if (region_re)
            begin
                line_count <= line_count + 1'b1;
            end

            case (state)
                ST_IDLE:
                begin
                    if (op_start)
                    begin
                        line_count <= '0;
                        iter_count <= '0;
                        if (cfg_use_props)
                        begin
                            state <= ST_FETCH_PROPS;
                        end
                        else if (cfg_length == '0 || cfg_source == SRC_NONE)
                        begin
                            op_done <= 1'b1;
                        end
                        else if (cfg_source == SRC_BRAM)
                        begin
                            state <= ST_BRAM_READ;
                        end
                        else
                        begin
                            // SRC_BOTH reads the FIFO.
                            state <= ST_FIFO_READ;
                        end
                    end
                end

                ST_FETCH_PROPS:
                begin
                    state <= ST_RECEIVE_PROPS;
                end

                ST_RECEIVE_PROPS:
                begin
                    if (props_rvalid && !empty_desc)
                    begin
                        state <= ST_READ_WITH_PROPS;
                    end
                end

                default:
                begin
                end
            endcase

            if (iter_end)
            begin
                line_count <= '0;
                iter_count <= iter_count + 1'b1;
                if (last_iter)
                begin
                    state   <= ST_IDLE;
                    op_done <= 1'b1;
                end
                else if (cfg_use_props)
                begin
                    state <= ST_FETCH_PROPS;
                end
            end
        end
    end

    // running offset and descriptor fields.
    always_ff @(posedge clk)
    begin
        push_data <= region_rdata;
        if (state == ST_IDLE && op_start)
        begin
            run_offset <= cfg_offset;
        end
        else if (iter_end && cfg_keep_count)
        begin
            run_offset <= run_offset + cfg_length;
        end
        if (state == ST_RECEIVE_PROPS && props_rvalid)
        begin
            desc_offset <= desc_word[CMD_OFFSET_MSB:CMD_OFFSET_LSB];
            desc_length <= desc_word[CMD_LENGTH_MSB:CMD_LENGTH_LSB];
        end
    end

    // the almost-full margin counts on a one-cycle store latency.
    a_region_latency : assert property (@(posedge clk) disable iff (reset)
        region_re |=> region_rvalid);

endmodule

`default_nettype wire

// ==== rtl/output_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module output_queue
    import region_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic [DATA_W-1:0]    push_data,
    input  logic                 out_ready,
    output logic                 almost_full,
    output logic                 out_valid,
    output logic [DATA_W-1:0]    out_data
);
    localparam int QAW = $clog2(OUTQ_DEPTH);

    logic [DATA_W-1:0] slots [0:OUTQ_DEPTH-1];
    logic [QAW-1:0]    wr_ptr;
    logic [QAW-1:0]    rd_ptr;
    logic [QAW:0]      count;
    logic              full;
    logic              pop;
    logic              write;

    assign full      = (count == (QAW+1)'(OUTQ_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = slots[rd_ptr];
    assign pop       = out_valid && out_ready;
    assign write     = push && !full;

    // leaves room for the words still in flight.
    assign almost_full = (count >= (QAW+1)'(OUTQ_DEPTH - OUTQ_MARGIN));

    always_ff @(posedge clk)
    begin
        if (write)
        begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + write;
            rd_ptr <= rd_ptr + pop;
            count  <= count + write - pop;
        end
    end

    a_no_push_full : assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule

`default_nettype wire

// ==== rtl/region_read_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_read_top
    import region_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  logic [DATA_W-1:0]    cmd_word,
    input  logic [ITER_W-1:0]    cmd_iterations,
    input  logic                 store_wr_en,
    input  logic                 store_wr_fifo,
    input  logic [STORE_AW-1:0]  store_wr_addr,
    input  logic [DATA_W-1:0]    store_wr_data,
    input  logic                 props_wr_en,
    input  logic [STORE_AW-1:0]  props_wr_addr,
    input  logic [PROPS_W-1:0]   props_wr_data,
    input  logic                 out_ready,
    output logic                 cmd_ready,
    output logic [7:0]           ops_done,
    output logic                 out_valid,
    output logic [DATA_W-1:0]    out_data
);
    logic                busy;
    logic                op_done;
    logic                op_start;
    read_source_e        cfg_source;
    logic [FIELD_W-1:0]  cfg_offset;
    logic [FIELD_W-1:0]  cfg_length;
    logic                cfg_use_props;
    logic                cfg_keep_count;
    logic [ITER_W-1:0]   cfg_iterations;
    logic                props_re;
    logic [STORE_AW-1:0] props_raddr;
    logic                props_rvalid;
    logic [PROPS_W-1:0]  props_rdata;
    logic                region_re;
    logic                region_rd_fifo;
    logic [STORE_AW-1:0] region_raddr;
    logic                region_rvalid;
    logic [DATA_W-1:0]   region_rdata;
    logic                region_empty;
    logic                push;
    logic [DATA_W-1:0]   push_data;
    logic                almost_full;

    read_config_regs u_read_config_regs (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_word       (cmd_word),
        .cmd_iterations (cmd_iterations),
        .busy           (busy),
        .op_done        (op_done),
        .cmd_ready      (cmd_ready),
        .op_start       (op_start),
        .cfg_source     (cfg_source),
        .cfg_offset     (cfg_offset),
        .cfg_length     (cfg_length),
        .cfg_use_props  (cfg_use_props),
        .cfg_keep_count (cfg_keep_count),
        .cfg_iterations (cfg_iterations),
        .ops_done       (ops_done)
    );

    // region words, from the BRAM or the FIFO.
    local_store #(.WIDTH(DATA_W)) u_region_store (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (store_wr_en),
        .wr_fifo (store_wr_fifo),
        .wr_addr (store_wr_addr),
        .wr_data (store_wr_data),
        .re      (region_re),
        .rd_fifo (region_rd_fifo),
        .raddr   (region_raddr),
        .rvalid  (region_rvalid),
        .rdata   (region_rdata),
        .empty   (region_empty)
    );

    // descriptor table, BRAM side only.
    local_store #(.WIDTH(PROPS_W)) u_props_store (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (props_wr_en),
        .wr_fifo (1'b0),
        .wr_addr (props_wr_addr),
        .wr_data (props_wr_data),
        .re      (props_re),
        .rd_fifo (1'b0),
        .raddr   (props_raddr),
        .rvalid  (props_rvalid),
        .rdata   (props_rdata),
        .empty   ()
    );

    region_reader u_region_reader (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .cfg_source     (cfg_source),
        .cfg_offset     (cfg_offset),
        .cfg_length     (cfg_length),
        .cfg_use_props  (cfg_use_props),
        .cfg_keep_count (cfg_keep_count),
        .cfg_iterations (cfg_iterations),
        .props_rvalid   (props_rvalid),
        .props_rdata    (props_rdata),
        .region_rvalid  (region_rvalid),
        .region_rdata   (region_rdata),
        .region_empty   (region_empty),
        .almost_full    (almost_full),
        .busy           (busy),
        .op_done        (op_done),
        .props_re       (props_re),
        .props_raddr    (props_raddr),
        .region_re      (region_re),
        .region_rd_fifo (region_rd_fifo),
        .region_raddr   (region_raddr),
        .push           (push),
        .push_data      (push_data)
    );

    output_queue u_output_queue (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_data   (push_data),
        .out_ready   (out_ready),
        .almost_full (almost_full),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// ==== verification/region_read_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_read_tb
    import region_read_pkg::*;
();
    logic                clk;
    logic                reset;
    logic                cmd_valid;
    logic [DATA_W-1:0]   cmd_word;
    logic [ITER_W-1:0]   cmd_iterations;
    logic                store_wr_en;
    logic                store_wr_fifo;
    logic [STORE_AW-1:0] store_wr_addr;
    logic [DATA_W-1:0]   store_wr_data;
    logic                props_wr_en;
    logic [STORE_AW-1:0] props_wr_addr;
    logic [PROPS_W-1:0]  props_wr_data;
    logic                out_ready;
    logic                cmd_ready;
    logic [7:0]          ops_done;
    logic                out_valid;
    logic [DATA_W-1:0]   out_data;

    // words still owed by the DUT, oldest first.
    logic [DATA_W-1:0]   exp_q [$];
    logic [8*32-1:0]     test_name;
    int unsigned         cycle_count = 0;
    int unsigned         cycle_limit = 2000;

    region_read_top u_region_read_top (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_word       (cmd_word),
        .cmd_iterations (cmd_iterations),
        .store_wr_en    (store_wr_en),
        .store_wr_fifo  (store_wr_fifo),
        .store_wr_addr  (store_wr_addr),
        .store_wr_data  (store_wr_data),
        .props_wr_en    (props_wr_en),
        .props_wr_addr  (props_wr_addr),
        .props_wr_data  (props_wr_data),
        .out_ready      (out_ready),
        .cmd_ready      (cmd_ready),
        .ops_done       (ops_done),
        .out_valid      (out_valid),
        .out_data       (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("Error: test %0s out_data expected %h actual %h",
                               test_name, expected, actual));
        end
    endtask

    task automatic check_ops(input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("Error: test %0s ops_done expected %0d actual %0d",
                               test_name, expected, actual));
        end
    endtask

    // all drivers below start and end on a falling edge.
    task automatic write_store(input logic fifo, input logic [STORE_AW-1:0] addr,
                               input logic [DATA_W-1:0] data);
        store_wr_en   = 1'b1;
        store_wr_fifo = fifo;
        store_wr_addr = addr;
        store_wr_data = data;
        @(negedge clk);
        store_wr_en   = 1'b0;
    endtask

    task automatic write_props(input logic [STORE_AW-1:0] addr,
                               input logic [PROPS_W-1:0] data);
        props_wr_en   = 1'b1;
        props_wr_addr = addr;
        props_wr_data = data;
        @(negedge clk);
        props_wr_en   = 1'b0;
    endtask

    task automatic send_command(input logic [DATA_W-1:0] word,
                                input logic [ITER_W-1:0] iters);
        cmd_valid      = 1'b1;
        cmd_word       = word;
        cmd_iterations = iters;
        while (!cmd_ready)
        begin
            @(negedge clk);
        end
        // accepted on the next rising edge.
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_words_left(input int left);
        while (exp_q.size() > left)
        begin
            @(negedge clk);
        end
    endtask

    task automatic wait_ops(input logic [7:0] count);
        while (ops_done < count)
        begin
            @(negedge clk);
        end
        check_ops(count, ops_done);
        wait_words_left(0);
        if (!cmd_ready)
        begin
            fail_run($sformatf("test %0s: cmd_ready stayed low after the last operation",
                               test_name));
        end
    endtask

    task automatic run_stimulus(input int fd);
        logic [7:0]          tag;
        logic [8*128-1:0]    rest;
        logic [STORE_AW-1:0] addr;
        logic [DATA_W-1:0]   word;
        logic [PROPS_W-1:0]  line;
        logic [ITER_W-1:0]   iters;
        int                  count;
        int                  code;

        code = $fscanf(fd, " %c", tag);
        while (code == 1)
        begin
            case (tag)
                "#": code = $fgets(rest, fd);
                "T": code = $fscanf(fd, " %s", test_name);
                "W":
                begin
                    code = $fscanf(fd, " %h %h", addr, word);
                    write_store(1'b0, addr, word);
                end
                "F":
                begin
                    code = $fscanf(fd, " %h", word);
                    write_store(1'b1, '0, word);
                end
                "P":
                begin
                    code = $fscanf(fd, " %h %h", addr, line);
                    write_props(addr, line);
                end
                "C":
                begin
                    code = $fscanf(fd, " %h %h", word, iters);
                    send_command(word, iters);
                end
                "E":
                begin
                    code = $fscanf(fd, " %h", word);
                    exp_q.push_back(word);
                    cycle_limit = cycle_limit + 200;
                end
                "Q":
                begin
                    code = $fscanf(fd, " %d", count);
                    wait_words_left(count);
                end
                "D":
                begin
                    code = $fscanf(fd, " %d", count);
                    wait_ops(8'(count));
                end
                default: fail_run($sformatf("unknown tag %c in the stimulus file", tag));
            endcase
            code = $fscanf(fd, " %c", tag);
        end
    endtask

    initial
    begin : stimulus
        int fd;

        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_word       = '0;
        cmd_iterations = '0;
        store_wr_en    = 1'b0;
        store_wr_fifo  = 1'b0;
        store_wr_addr  = '0;
        store_wr_data  = '0;
        props_wr_en    = 1'b0;
        props_wr_addr  = '0;
        props_wr_data  = '0;
        test_name      = "reset";
        repeat (16) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("verification/region_read_stimulus.txt", "r");
        if (fd == 0)
        begin
            fail_run("could not open the stimulus file");
        end
        else
        begin
            run_stimulus(fd);
            $fclose(fd);
            if (exp_q.size() != 0)
            begin
                fail_run($sformatf("%0d expected words never came out", exp_q.size()));
            end
            else
            begin
                $display("sim passed");
                $finish;
            end
        end
    end

    // random stall on the output, about one cycle in three.
    initial
    begin : output_side
        int unsigned      seed_val;
        logic [DATA_W-1:0] expected;

        out_ready = 1'b0;
        seed_val  = $urandom(32'h3500);
        forever
        begin
            @(negedge clk);
            out_ready = (($urandom % 3) != 0);
            // a word shown now leaves on the coming rising edge.
            if (!reset && out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    fail_run($sformatf("test %0s: unexpected output word %h",
                                       test_name, out_data));
                end
                else
                begin
                    expected = exp_q.pop_front();
                    check_word(expected, out_data);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            fail_run($sformatf("timeout after %0d cycles in test %0s",
                               cycle_count, test_name));
        end
    end

endmodule

`default_nettype wire

// ==== verification/region_read_stimulus.txt ====
# T name | W addr word | F word | P addr line | C cmd_word iterations | E expected word
# Q wait until at most n expected words are left | D wait for ops_done n; words in hex
T bram_repeat
W 10 aaaa0010
W 11 aaaa0011
W 12 aaaa0012
W 13 aaaa0013
C 40020010 3
E aaaa0010
E aaaa0011
E aaaa0010
E aaaa0011
E aaaa0010
E aaaa0011
D 1
T bram_keep_count
C 40028010 2
E aaaa0010
E aaaa0011
E aaaa0012
E aaaa0013
D 2
T fifo_pause
F bbbb0000
F bbbb0001
C 80030000 1
E bbbb0000
E bbbb0001
E bbbb0002
Q 1
F bbbb0002
F bbbb0003
D 3
T fifo_leftover
C c0010000 1
E bbbb0003
D 4
T props_desc
P 00 00000000000100120002001000000000
C 0001c001 2
E aaaa0010
E aaaa0011
E aaaa0012
D 5
T empty_cmds
C 40000010 1
C 00020010 1
D 7

// ==== region_read.f ====
rtl/region_read_pkg.sv
rtl/read_config_regs.sv
rtl/local_store.sv
rtl/region_reader.sv
rtl/output_queue.sv
rtl/region_read_top.sv
verification/region_read_tb.sv
